// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // width of a byte address on the instruction memory bus.
  localparam int ADDR_W = 32;

  // width of one data word returned by the bus.
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // number of index bits in the direct-mapped cache, 8 lines by default.
  localparam int INDEX_BITS = 3;

  // every line holds one 32-bit word, so two byte-offset bits sit below the index.
  localparam int OFFSET_BITS = 2;

  // fence.i encoding.
  // when this word is refilled the whole cache is invalidated.
  localparam bus_pkg::data_t FENCE_I = 32'h0000_100f;

  // one fetched instruction together with the address it came from.
  typedef struct packed {
    bus_pkg::addr_t pc;
    bus_pkg::data_t inst;
  } fetch_t;

endpackage

`default_nettype wire

// File: hw/mem_rd_if.sv
`default_nettype none

// read channel between the fetch cache and the bus port.
// the address phase uses a valid/ready handshake, and the data phase is a single rvalid pulse.
interface mem_rd_if;

  bus_pkg::addr_t araddr;
  logic           arvalid;
  logic           arready;
  bus_pkg::data_t rdata;
  logic           rvalid;

  modport master (
    output araddr,
    output arvalid,
    input  arready,
    input  rdata,
    input  rvalid
  );

  modport slave (
    input  araddr,
    input  arvalid,
    output arready,
    output rdata,
    output rvalid
  );

endinterface

`default_nettype wire

// File: hw/fetch_pc_gen.sv
`default_nettype none

module fetch_pc_gen #(
  parameter bus_pkg::addr_t reset_pc = 32'h8000_0000
) (
  input  wire                 clk,
  input  wire                 rst,

  input  wire                 redirect_i,
  input  wire bus_pkg::addr_t redirect_pc_i,

  input  wire                 pc_ready_i,
  output logic                pc_valid_o,
  output bus_pkg::addr_t      pc_o
);

  bus_pkg::addr_t pc_q;
  logic           valid_q;
  logic           step;

  // the fetch address moves on only when the cache has taken it.
  assign step = valid_q && pc_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q    <= reset_pc;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b1;
      // a redirect wins over the sequential step.
      if (redirect_i)
      begin
        pc_q <= redirect_pc_i;
      end
      else if (step)
      begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  assign pc_valid_o = valid_q;
  assign pc_o       = pc_q;

endmodule

`default_nettype wire

// File: hw/fetch_icache.sv
`default_nettype none

module fetch_icache #(
  parameter int unsigned index_bits = fetch_pkg::INDEX_BITS
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 redirect_i,

  input  wire                 pc_valid_i,
  input  wire bus_pkg::addr_t pc_i,
  output logic                pc_ready_o,

  mem_rd_if.master            mem,

  output logic                out_valid_o,
  output fetch_pkg::fetch_t   out_o,
  input  wire                 out_ready_i
);

  localparam int lines    = 1 << index_bits;
  localparam int tag_bits = bus_pkg::ADDR_W - index_bits - fetch_pkg::OFFSET_BITS;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } state_t;

  state_t                state_q;

  logic [tag_bits-1:0]   tag_q [lines];
  bus_pkg::data_t        data_q [lines];
  logic [lines-1:0]      line_valid_q;

  bus_pkg::addr_t        miss_pc_q;
  logic                  cancel_q;

  logic                  out_valid_q;
  fetch_pkg::fetch_t     out_q;

  logic [index_bits-1:0] pc_idx;
  logic [tag_bits-1:0]   pc_tag;
  logic [index_bits-1:0] miss_idx;
  logic [tag_bits-1:0]   miss_tag;
  logic                  hit;
  logic                  accept;
  logic                  refill;

  assign pc_idx   = pc_i[fetch_pkg::OFFSET_BITS +: index_bits];
  assign pc_tag   = pc_i[bus_pkg::ADDR_W-1 -: tag_bits];
  assign miss_idx = miss_pc_q[fetch_pkg::OFFSET_BITS +: index_bits];
  assign miss_tag = miss_pc_q[bus_pkg::ADDR_W-1 -: tag_bits];

  // the lookup is done on the incoming pc, in the cycle it is offered.
  assign hit = line_valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);

  // a new pc is taken only while idle and when the output register is free or draining.
  assign pc_ready_o = (state_q == S_IDLE) && !redirect_i && (!out_valid_q || out_ready_i);
  assign accept     = pc_valid_i && pc_ready_o;
  assign refill     = (state_q == S_DATA) && mem.rvalid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q      <= S_IDLE;
      out_valid_q  <= 1'b0;
      line_valid_q <= '0;
      cancel_q     <= 1'b0;
    end
    else
    begin
      if (out_valid_q && out_ready_i)
      begin
        out_valid_q <= 1'b0;
      end
      case (state_q)
        S_IDLE:
        begin
          if (accept && hit)
          begin
            out_valid_q <= 1'b1;
          end
          else if (accept)
          begin
            state_q  <= S_ADDR;
            cancel_q <= 1'b0;
          end
        end
        S_ADDR:
        begin
          if (mem.arready)
          begin
            state_q <= S_DATA;
          end
        end
        S_DATA:
        begin
          if (mem.rvalid)
          begin
            state_q                <= S_IDLE;
            line_valid_q[miss_idx] <= 1'b1;
            // fence.i drops every line, the one just filled included.
            if (mem.rdata == fetch_pkg::FENCE_I)
            begin
              line_valid_q <= '0;
            end
            if (!cancel_q)
            begin
              out_valid_q <= 1'b1;
            end
          end
        end
        default:
        begin
          state_q <= S_IDLE;
        end
      endcase
      // a redirect empties the output and turns a pending miss into a plain refill.
      if (redirect_i)
      begin
        out_valid_q <= 1'b0;
        if (state_q != S_IDLE)
        begin
          cancel_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept && hit)
    begin
      out_q.pc   <= pc_i;
      out_q.inst <= data_q[pc_idx];
    end
    else if (accept)
    begin
      miss_pc_q <= pc_i;
    end
    if (refill)
    begin
      data_q[miss_idx] <= mem.rdata;
      tag_q[miss_idx]  <= miss_tag;
      out_q.pc         <= miss_pc_q;
      out_q.inst       <= mem.rdata;
    end
  end

  assign mem.araddr  = {miss_pc_q[bus_pkg::ADDR_W-1:fetch_pkg::OFFSET_BITS],
                        {fetch_pkg::OFFSET_BITS{1'b0}}};
  assign mem.arvalid = (state_q == S_ADDR);

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

endmodule

`default_nettype wire

// File: hw/fetch_bus_port.sv
`default_nettype none

module fetch_bus_port (
  input  wire                 clk,
  input  wire                 rst,

  mem_rd_if.slave             mem,

  output bus_pkg::addr_t      mem_araddr_o,
  output logic                mem_arvalid_o,
  input  wire                 mem_arready_i,
  input  wire bus_pkg::data_t mem_rdata_i,
  input  wire                 mem_rvalid_i
);

  bus_pkg::addr_t araddr_q;
  logic           arvalid_q;
  logic           busy_q;
  logic           take;

  // only one read may be outstanding, so the port is closed until its data is back.
  assign mem.arready = !busy_q;
  assign take        = mem.arvalid && !busy_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arvalid_q <= 1'b0;
      busy_q    <= 1'b0;
    end
    else
    begin
      if (take)
      begin
        arvalid_q <= 1'b1;
        busy_q    <= 1'b1;
      end
      else
      begin
        if (arvalid_q && mem_arready_i)
        begin
          arvalid_q <= 1'b0;
        end
        if (mem_rvalid_i)
        begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      araddr_q <= mem.araddr;
    end
  end

  assign mem_araddr_o  = araddr_q;
  assign mem_arvalid_o = arvalid_q;

  // responses that arrive with no read pending are dropped.
  assign mem.rdata  = mem_rdata_i;
  assign mem.rvalid = mem_rvalid_i && busy_q;

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`default_nettype none

module fetch_top #(
  parameter bus_pkg::addr_t reset_pc   = 32'h8000_0000,
  parameter int unsigned    index_bits = fetch_pkg::INDEX_BITS
) (
  input  wire                 clk,
  input  wire                 rst,

  input  wire                 redirect_i,
  input  wire bus_pkg::addr_t redirect_pc_i,

  output bus_pkg::addr_t      mem_araddr_o,
  output logic                mem_arvalid_o,
  input  wire                 mem_arready_i,
  input  wire bus_pkg::data_t mem_rdata_i,
  input  wire                 mem_rvalid_i,

  output logic                inst_valid_o,
  output bus_pkg::data_t      inst_o,
  output bus_pkg::addr_t      inst_pc_o,
  input  wire                 inst_ready_i
);

  logic              pc_valid;
  logic              pc_ready;
  bus_pkg::addr_t    pc;
  fetch_pkg::fetch_t fetch;

  mem_rd_if rd_if ();

  fetch_pc_gen #(
    .reset_pc (reset_pc)
  ) pc_gen_inst (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_ready_i    (pc_ready),
    .pc_valid_o    (pc_valid),
    .pc_o          (pc)
  );

  fetch_icache #(
    .index_bits (index_bits)
  ) icache_inst (
    .clk         (clk),
    .rst         (rst),
    .redirect_i  (redirect_i),
    .pc_valid_i  (pc_valid),
    .pc_i        (pc),
    .pc_ready_o  (pc_ready),
    .mem         (rd_if.master),
    .out_valid_o (inst_valid_o),
    .out_o       (fetch),
    .out_ready_i (inst_ready_i)
  );

  fetch_bus_port bus_port_inst (
    .clk           (clk),
    .rst           (rst),
    .mem           (rd_if.slave),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_arready_i (mem_arready_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

  // the stream carries the instruction word and its address side by side.
  assign inst_o    = fetch.inst;
  assign inst_pc_o = fetch.pc;

endmodule

`default_nettype wire

// File: verification/fetch_tb_mem.sv
`default_nettype none

// memory model on the external read bus.
// it takes one address at a time and answers after a random number of cycles.
module fetch_tb_mem #(
  parameter int seed_init = 58170
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire bus_pkg::addr_t fence_addr_i,
  input  wire bus_pkg::addr_t araddr_i,
  input  wire                 arvalid_i,
  output logic                arready_o,
  output bus_pkg::data_t      rdata_o,
  output logic                rvalid_o,
  output int                  read_count_o
);

  integer         seed = seed_init;
  logic           arready_q = 1'b0;
  logic           rvalid_q = 1'b0;
  bus_pkg::data_t rdata_q = '0;
  bus_pkg::addr_t addr_q = '0;
  logic           busy_q = 1'b0;
  int             wait_q = 0;
  int             count_q = 0;

  // the word at an address is the address with its upper half inverted.
  function automatic bus_pkg::data_t word_at(input bus_pkg::addr_t a);
    if (a == fence_addr_i)
    begin
      return fetch_pkg::FENCE_I;
    end
    return {~a[31:16], a[15:0]};
  endfunction

  // outputs change on the falling edge so the DUT sees them settled.
  always @(negedge clk)
  begin
    if (rst)
    begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      busy_q    <= 1'b0;
      count_q   <= 0;
    end
    else
    begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      if (!busy_q && arvalid_i && !arready_q)
      begin
        arready_q <= 1'b1;
        addr_q    <= araddr_i;
        busy_q    <= 1'b1;
        wait_q    <= int'($unsigned($random(seed)) % 4);
        count_q   <= count_q + 1;
      end
      else if (busy_q && !arready_q)
      begin
        if (wait_q == 0)
        begin
          rvalid_q <= 1'b1;
          rdata_q  <= word_at(addr_q);
          busy_q   <= 1'b0;
        end
        else
        begin
          wait_q <= wait_q - 1;
        end
      end
    end
  end

  assign arready_o    = arready_q;
  assign rvalid_o     = rvalid_q;
  assign rdata_o      = rdata_q;
  assign read_count_o = count_q;

endmodule

`default_nettype wire

// File: verification/fetch_tb.sv
`default_nettype none

module fetch_tb;

  localparam bus_pkg::addr_t reset_pc = 32'h8000_0000;
  localparam int item_count = 35;
  localparam int item_cycles = 25;
  localparam int wait_limit = 40;
  localparam int limit_cycles = item_count * item_cycles + 100;

  logic           clk = 1'b0;
  logic           rst;
  logic           redirect_i;
  bus_pkg::addr_t redirect_pc_i;
  logic           inst_ready_i;
  bus_pkg::addr_t fence_addr;
  integer         seed = 58170;

  bus_pkg::addr_t mem_araddr;
  logic           mem_arvalid;
  logic           mem_arready;
  bus_pkg::data_t mem_rdata;
  logic           mem_rvalid;
  int             read_count;
  logic           inst_valid_o;
  bus_pkg::data_t inst_o;
  bus_pkg::addr_t inst_pc_o;

  always #5 clk = ~clk;

  fetch_top #(
    .reset_pc   (reset_pc),
    .index_bits (fetch_pkg::INDEX_BITS)
  ) fetch_top_inst (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mem_araddr_o  (mem_araddr),
    .mem_arvalid_o (mem_arvalid),
    .mem_arready_i (mem_arready),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .inst_ready_i  (inst_ready_i)
  );

  fetch_tb_mem #(
    .seed_init (58170)
  ) mem_inst (
    .clk          (clk),
    .rst          (rst),
    .fence_addr_i (fence_addr),
    .araddr_i     (mem_araddr),
    .arvalid_i    (mem_arvalid),
    .arready_o    (mem_arready),
    .rdata_o      (mem_rdata),
    .rvalid_o     (mem_rvalid),
    .read_count_o (read_count)
  );

  function automatic bus_pkg::data_t expected_word(input bus_pkg::addr_t a);
    if (a == fence_addr)
    begin
      return fetch_pkg::FENCE_I;
    end
    return {~a[31:16], a[15:0]};
  endfunction

  task automatic fail_now;
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string what, input bus_pkg::addr_t got,
                            input bus_pkg::addr_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_now();
    end
  endtask

  task automatic check_data(input string what, input bus_pkg::data_t got,
                            input bus_pkg::data_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_now();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      fail_now();
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
    begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      fail_now();
    end
  endtask

  // waits for the next instruction, holds it for a random stall and then takes it.
  // the last item of a run is left in the output so that no further fetch starts.
  task automatic take_inst(input bus_pkg::addr_t exp_pc, input bit last);
    int waited;
    int stall;
    begin
      waited = 0;
      while (!inst_valid_o)
      begin
        waited++;
        if (waited > wait_limit)
        begin
          $display("no instruction arrived for pc %h in time", exp_pc);
          fail_now();
        end
        @(negedge clk);
      end
      check_addr("inst_pc_o", inst_pc_o, exp_pc);
      check_data("inst_o", inst_o, expected_word(exp_pc));
      stall = int'($unsigned($random(seed)) % 4);
      repeat (stall)
      begin
        @(negedge clk);
        check_bit("inst_valid_o while stalled", inst_valid_o, 1'b1);
        check_addr("inst_pc_o while stalled", inst_pc_o, exp_pc);
        check_data("inst_o while stalled", inst_o, expected_word(exp_pc));
      end
      if (!last)
      begin
        inst_ready_i = 1'b1;
        @(negedge clk);
        inst_ready_i = 1'b0;
      end
    end
  endtask

  task automatic run_sequence(input bus_pkg::addr_t start, input int n);
    for (int i = 0; i < n; i++)
    begin
      take_inst(start + 32'(4 * i), i == n - 1);
    end
  endtask

  task automatic redirect_to(input bus_pkg::addr_t target);
    inst_ready_i  = 1'b0;
    redirect_pc_i = target;
    redirect_i    = 1'b1;
    @(negedge clk);
    redirect_i = 1'b0;
  endtask

  task automatic test_reset_and_sequential;
    repeat (5)
    begin
      @(negedge clk);
      check_bit("inst_valid_o in reset", inst_valid_o, 1'b0);
      check_bit("mem_arvalid_o in reset", mem_arvalid, 1'b0);
    end
    rst = 1'b0;
    run_sequence(reset_pc, 8);
    check_count("reads after cold fetch", read_count, 8);
  endtask

  task automatic test_hits;
    int base;
    begin
      base = read_count;
      redirect_to(reset_pc);
      run_sequence(reset_pc, 8);
      check_count("reads after cached refetch", read_count, base);
    end
  endtask

  // 32 bytes apart means the same index with a different tag.
  task automatic test_conflict;
    int base;
    begin
      base = read_count;
      redirect_to(reset_pc + 32'h20);
      run_sequence(reset_pc + 32'h20, 1);
      check_count("reads after conflicting fetch", read_count, base + 1);
      redirect_to(reset_pc);
      run_sequence(reset_pc, 1);
      check_count("reads after return to evicted line", read_count, base + 2);
    end
  endtask

  task automatic test_backpressure;
    int base;
    begin
      base = read_count;
      redirect_to(reset_pc + 32'h40);
      run_sequence(reset_pc + 32'h40, 12);
      check_count("reads under back-pressure", read_count, base + 12);
    end
  endtask

  // lines 0x54 and 0x58 were left cached by the back-pressure run.
  task automatic test_fence;
    int base;
    begin
      base = read_count;
      fence_addr = reset_pc + 32'h100;
      redirect_to(fence_addr);
      run_sequence(fence_addr, 1);
      check_count("reads for fence word", read_count, base + 1);
      redirect_to(reset_pc + 32'h54);
      run_sequence(reset_pc + 32'h54, 2);
      check_count("reads after fence", read_count, base + 3);
    end
  endtask

  task automatic test_redirect_miss;
    int base;
    int waited;
    begin
      base = read_count;
      waited = 0;
      redirect_to(reset_pc + 32'h200);
      while (!mem_arvalid)
      begin
        waited++;
        if (waited > wait_limit)
        begin
          $display("the miss for the cancelled address never reached the bus");
          fail_now();
        end
        @(negedge clk);
      end
      check_addr("mem_araddr_o", mem_araddr, reset_pc + 32'h200);
      redirect_to(reset_pc + 32'h300);
      run_sequence(reset_pc + 32'h300, 2);
      check_count("reads with a cancelled miss", read_count, base + 3);
    end
  endtask

  initial
  begin
    #(limit_cycles * 10);
    $display("watchdog timeout, the tests did not finish in time");
    fail_now();
  end

  initial
  begin
    rst           = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    inst_ready_i  = 1'b0;
    fence_addr    = '0;
    test_reset_and_sequential();
    test_hits();
    test_conflict();
    test_backpressure();
    test_fence();
    test_redirect_miss();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hw/bus_pkg.sv
hw/fetch_pkg.sv
hw/mem_rd_if.sv
hw/fetch_pc_gen.sv
hw/fetch_icache.sv
hw/fetch_bus_port.sv
hw/fetch_top.sv
verification/fetch_tb_mem.sv
verification/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Builds the fetch testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal gives a failing status.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  -f compile.f \
  --top-module fetch_tb \
  -o fetch_tb_sim \
  && ./obj_dir/fetch_tb_sim \
  || exit 1
